//--- des_search.f
verilog/des_search_pkg.sv
verilog/des_search_ctrl.sv
verilog/message_counter.sv
verilog/des_round_unit.sv
verilog/linear_match.sv
verilog/des_search.sv
tests/des_search_props.sv
tests/tb_des_search.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the des_search testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_des_search \
    -f des_search.f \
    -o sim_des_search

./obj_dir/sim_des_search | tee "$LOG"

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- tests/des_search_props.sv
`timescale 1ns/1ps

module des_search_props (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic test_res_ready,
    input logic start_search,
    input logic cmd_read
);

    // Search result and test result are separate modes
    done_test_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(done && test_res_ready)
    ) else $error("done and test_res_ready high together");

    start_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) start_search |=> !start_search
    ) else $error("start_search held for more than one cycle");

    cmd_read_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !cmd_read
    ) else $error("cmd_read high in the cycle after reset");

endmodule

bind des_search_ctrl des_search_props props0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .done           (done),
    .test_res_ready (test_res_ready),
    .start_search   (start_search),
    .cmd_read       (cmd_read)
);

//--- tests/tb_des_search.sv
`timescale 1ns/1ps

module tb_des_search
    import des_search_pkg::*;
();

    localparam int MSGS = 1 << INDEX_BITS;
    localparam int CYCLE_LIMIT = 4 * MSGS * (ROUNDS + 3) + 2000;
    localparam int TEST_STEPS = 6;

    logic   clk;
    logic   rst_n;
    cmd_t   cmd;
    logic   cmd_valid;
    logic   advance_test_cmd;
    cmd_t   region;
    logic   cmd_read;
    cmd_t   cmd_read_data;
    logic   test_res_ready;
    logic   done;
    count_t counter;
    block_t ciphertext;

    count_t exp_counts[$];
    block_t exp_ciphers[$];
    logic   done_q;
    logic   ready_q;
    int     cycles;

    des_search dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .advance_test_cmd (advance_test_cmd),
        .region           (region),
        .cmd_read         (cmd_read),
        .cmd_read_data    (cmd_read_data),
        .test_res_ready   (test_res_ready),
        .done             (done),
        .counter          (counter),
        .ciphertext       (ciphertext)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reduced-round DES, no IP or FP
    function automatic block_t encrypt(input block_t pt);
        half_t l;
        half_t r;
        half_t t;
        l = pt[63:32];
        r = pt[31:0];
        for (int i = 0; i < ROUNDS; i++) begin
            t = r;
            r = l ^ des_f(r, ROUND_KEYS[i]);
            l = t;
        end
        return {r, l};   // Halves swapped back at the end
    endfunction

    // Messages of a region whose masked parities agree
    function automatic count_t region_matches(input cmd_t reg_word);
        block_t pt;
        block_t ct;
        count_t n;
        n = '0;
        for (int i = 0; i < MSGS; i++) begin
            pt = {region_t'(reg_word), index_t'(i)};
            ct = encrypt(pt);
            if ((^(pt & MASK_IN)) == (^(ct & MASK_OUT))) begin
                n = n + 64'd1;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Host side of the level command protocol
    task automatic send_cmd(input cmd_t code, input cmd_t reg_word);
        cmd = code;
        region = reg_word;
        cmd_valid = 1'b1;
        while (!cmd_read) begin
            tick();
        end
        cmd_valid = 1'b0;
        while (cmd_read) begin
            tick();
        end
        check_value("cmd_read_data", 64'(cmd_read_data), 64'(code));
    endtask

    task automatic wait_done();
        while (!done) begin
            tick();
        end
    endtask

    // Comparing process, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            done_q = 1'b0;
            ready_q = 1'b0;
        end else begin
            if (done && !done_q) begin
                if (exp_counts.size() == 0) begin
                    stop_with_error("done rose although no search was running");
                end else begin
                    check_value("counter", counter, exp_counts.pop_front());
                end
            end
            if (test_res_ready && !ready_q) begin
                if (exp_ciphers.size() == 0) begin
                    stop_with_error("test_res_ready rose with no test result expected");
                end else begin
                    check_value("ciphertext", ciphertext, exp_ciphers.pop_front());
                end
            end
            done_q = done;
            ready_q = test_res_ready;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_error($sformatf("timeout, no finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        cmd_t   region_a;
        cmd_t   region_b;
        count_t count_b;
        rst_n = 1'b0;
        cmd = '0;
        cmd_valid = 1'b0;
        advance_test_cmd = 1'b0;
        region = '0;
        cycles = 0;
        region_a = $urandom(32'hfed2_4626);
        region_b = $urandom();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();
        check_value("done", 64'(done), 64'd0);
        check_value("cmd_read", 64'(cmd_read), 64'd0);
        check_value("test_res_ready", 64'(test_res_ready), 64'd0);
        check_value("cmd_read_data", 64'(cmd_read_data), 64'd0);

        // Unknown code is ignored
        cmd = 32'd9;
        cmd_valid = 1'b1;
        repeat (8) begin
            tick();
            check_value("cmd_read", 64'(cmd_read), 64'd0);
        end
        cmd_valid = 1'b0;
        repeat (4) tick();
        check_value("cmd_read_data", 64'(cmd_read_data), 64'd0);

        send_cmd(CMD_READ_REGION, region_a);
        exp_counts.push_back(region_matches(region_a));
        send_cmd(CMD_START, region_a);
        wait_done();
        send_cmd(CMD_RESTART, region_a);
        check_value("done", 64'(done), 64'd0);

        count_b = region_matches(region_b);
        send_cmd(CMD_READ_REGION, region_b);
        exp_counts.push_back(count_b);
        send_cmd(CMD_START, region_b);
        wait_done();
        send_cmd(CMD_RESTART, region_b);

        // Test mode, one message per advance
        for (int i = 0; i < TEST_STEPS; i++) begin
            exp_ciphers.push_back(encrypt({region_t'(region_b), index_t'(i)}));
        end
        send_cmd(CMD_TEST_MODE, region_b);
        for (int i = 0; i < TEST_STEPS; i++) begin
            while (!test_res_ready) begin
                tick();
            end
            if (i < TEST_STEPS - 1) begin
                advance_test_cmd = 1'b1;
                while (test_res_ready) begin
                    tick();
                end
                advance_test_cmd = 1'b0;
            end
        end
        send_cmd(CMD_RESTART, region_b);
        check_value("test_res_ready", 64'(test_res_ready), 64'd0);

        // Abort a running search, then repeat it
        send_cmd(CMD_START, region_b);
        repeat (40) tick();
        check_value("done", 64'(done), 64'd0);
        send_cmd(CMD_RESTART, region_b);
        check_value("done", 64'(done), 64'd0);
        exp_counts.push_back(count_b);
        send_cmd(CMD_START, region_b);
        wait_done();
        tick();

        if (exp_counts.size() == 0 && exp_ciphers.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Some expected results were never produced by the DUT");
            $display("*** TEST FAILED ***");
            $fatal(1, "Results missing at end of run");
        end
    end

endmodule

//--- verilog/des_round_unit.sv
`timescale 1ns/1ps

module des_round_unit
    import des_search_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    load,
    input  region_t region_sel,
    input  index_t  index,
    input  logic    restart_search,
    output logic    busy,
    output logic    block_valid,
    output block_t  plaintext,
    output block_t  cipher_out
);

    block_t next_pt;
    half_t  l_half;
    half_t  r_half;
    round_t rnd;
    logic   running;
    logic   finish;    // All rounds applied, swap pending
    logic   accept;

    assign next_pt = {region_sel, index};
    assign busy = running || finish;
    assign accept = load && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n || restart_search) begin
            running <= 1'b0;
            finish <= 1'b0;
            block_valid <= 1'b0;
            rnd <= '0;
        end else begin
            block_valid <= 1'b0;
            if (accept) begin
                running <= 1'b1;
                rnd <= '0;
            end else if (running) begin
                if (rnd == LAST_ROUND) begin
                    running <= 1'b0;
                    finish <= 1'b1;
                end else begin
                    rnd <= rnd + 1'b1;
                end
            end else if (finish) begin
                finish <= 1'b0;
                block_valid <= 1'b1;
            end
        end
    end

    // Feistel halves, one round per clock
    always_ff @(posedge clk) begin
        if (accept) begin
            plaintext <= next_pt;
            l_half <= next_pt[63:32];
            r_half <= next_pt[31:0];
        end else if (running) begin
            l_half <= r_half;
            r_half <= l_half ^ des_f(r_half, ROUND_KEYS[rnd]);
        end
        if (finish) begin
            cipher_out <= {r_half, l_half};   // Undo the last swap
        end
    end

endmodule

//--- verilog/des_search.sv
`timescale 1ns/1ps

module des_search
    import des_search_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  cmd_t   cmd,
    input  logic   cmd_valid,
    input  logic   advance_test_cmd,
    input  cmd_t   region,
    output logic   cmd_read,
    output cmd_t   cmd_read_data,
    output logic   test_res_ready,
    output logic   done,
    output count_t counter,
    output block_t ciphertext
);

    logic    start_search;
    logic    restart_search;
    logic    test_enabled;
    logic    test_advance;
    region_t region_sel;
    index_t  index;
    logic    exhausted;
    logic    busy;
    logic    block_valid;
    block_t  plaintext;
    block_t  cipher_out;
    count_t  match_count;
    logic    msg_load;
    logic    next_msg;

    assign msg_load = ~exhausted;   // A message is pending
    assign next_msg = ~busy;        // Round unit idle

    des_search_ctrl ctrl0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .advance_test_cmd (advance_test_cmd),
        .region           (region),
        .search_done      (exhausted),
        .block_valid      (block_valid),
        .match_count      (match_count),
        .cipher_out       (cipher_out),
        .cmd_read         (cmd_read),
        .cmd_read_data    (cmd_read_data),
        .test_res_ready   (test_res_ready),
        .done             (done),
        .counter          (counter),
        .ciphertext       (ciphertext),
        .start_search     (start_search),
        .restart_search   (restart_search),
        .test_enabled     (test_enabled),
        .test_advance     (test_advance),
        .region_sel       (region_sel)
    );

    message_counter msg_cnt0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_search   (start_search),
        .restart_search (restart_search),
        .test_enabled   (test_enabled),
        .test_advance   (test_advance),
        .next_msg       (next_msg),
        .index          (index),
        .exhausted      (exhausted)
    );

    des_round_unit round0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (msg_load),
        .region_sel     (region_sel),
        .index          (index),
        .restart_search (restart_search),
        .busy           (busy),
        .block_valid    (block_valid),
        .plaintext      (plaintext),
        .cipher_out     (cipher_out)
    );

    linear_match match0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (start_search),
        .block_valid (block_valid),
        .plaintext   (plaintext),
        .cipher_out  (cipher_out),
        .match_count (match_count)
    );

endmodule

//--- verilog/des_search_ctrl.sv
`timescale 1ns/1ps

module des_search_ctrl
    import des_search_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  cmd_t    cmd,
    input  logic    cmd_valid,
    input  logic    advance_test_cmd,
    input  cmd_t    region,
    input  logic    search_done,
    input  logic    block_valid,
    input  count_t  match_count,
    input  block_t  cipher_out,
    output logic    cmd_read,
    output cmd_t    cmd_read_data,
    output logic    test_res_ready,
    output logic    done,
    output count_t  counter,
    output block_t  ciphertext,
    output logic    start_search,
    output logic    restart_search,
    output logic    test_enabled,
    output logic    test_advance,
    output region_t region_sel
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic cmd_valid_meta;
    logic cmd_valid_sync;
    logic advance_meta;
    logic advance_sync;
    logic restart_req;

    // Two-flop synchronizers for the host levels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid_meta <= 1'b0;
            cmd_valid_sync <= 1'b0;
            advance_meta <= 1'b0;
            advance_sync <= 1'b0;
        end else begin
            cmd_valid_meta <= cmd_valid;
            cmd_valid_sync <= cmd_valid_meta;
            advance_meta <= advance_test_cmd;
            advance_sync <= advance_meta;
        end
    end

    assign restart_req = cmd_valid_sync && (cmd == CMD_RESTART);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= init;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            init: begin
                if (cmd_valid_sync) begin
                    case (cmd)
                        CMD_READ_REGION: next_state = set_region;
                        CMD_START:       next_state = start_init;
                        CMD_TEST_MODE:   next_state = test_init;
                        CMD_RESTART:     next_state = restart;
                        default:         next_state = init;   // Unknown code ignored
                    endcase
                end
            end
            set_region, restart: begin
                if (!cmd_valid_sync) begin
                    next_state = init;
                end
            end
            start_init: begin
                if (!cmd_valid_sync) begin
                    next_state = start;
                end
            end
            test_init: begin
                if (!cmd_valid_sync) begin
                    next_state = test_start;
                end
            end
            start:      next_state = waiting;
            test_start: next_state = test_mode;
            waiting: begin
                if (restart_req) begin
                    next_state = restart;
                end else if (search_done && block_valid) begin
                    next_state = finishing;   // Last message just finished
                end
            end
            finishing: begin
                if (restart_req) begin
                    next_state = restart;
                end
            end
            test_mode: begin
                if (restart_req) begin
                    next_state = restart;
                end else if (advance_sync) begin
                    next_state = advance_test;
                end
            end
            advance_test: next_state = advance_test_wait;
            advance_test_wait: begin
                if (!advance_sync) begin
                    next_state = test_mode;
                end
            end
            default: next_state = init;
        endcase
    end

    assign cmd_read = (state == set_region) || (state == start_init) ||
                      (state == test_init) || (state == restart);
    assign start_search = (state == start) || (state == test_start);
    assign restart_search = (state == restart);
    assign test_advance = (state == advance_test);
    assign test_enabled = state inside {test_start, test_mode, advance_test, advance_test_wait};

    always_ff @(posedge clk) begin
        if (state == set_region) begin
            region_sel <= region_t'(region);   // Zero-extended into the upper plaintext bits
        end
        if (state == finishing) begin
            counter <= match_count;
        end
        if (test_enabled && block_valid) begin
            ciphertext <= cipher_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
            test_res_ready <= 1'b0;
        end else begin
            done <= (state == finishing);   // Rises with the counter capture
            if (restart_search || test_advance) begin
                test_res_ready <= 1'b0;
            end else if (test_enabled && block_valid) begin
                test_res_ready <= 1'b1;
            end
        end
    end

    // Last accepted command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_read_data <= '0;
        end else begin
            case (state)
                set_region: cmd_read_data <= CMD_READ_REGION;
                start_init: cmd_read_data <= CMD_START;
                test_init:  cmd_read_data <= CMD_TEST_MODE;
                restart:    cmd_read_data <= CMD_RESTART;
                default:    cmd_read_data <= cmd_read_data;
            endcase
        end
    end

endmodule

//--- verilog/des_search_pkg.sv
package des_search_pkg;

    localparam int REGION_BITS = 56;
    localparam int INDEX_BITS = 64 - REGION_BITS;   // 256 messages per region
    localparam int ROUNDS = 8;

    typedef logic [31:0] cmd_t;
    typedef logic [63:0] block_t;
    typedef logic [31:0] half_t;
    typedef logic [47:0] subkey_t;
    typedef logic [REGION_BITS-1:0] region_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [63:0] count_t;
    typedef logic [$clog2(ROUNDS)-1:0] round_t;

    typedef enum logic [3:0] {
        init,
        set_region,
        start_init,
        start,
        waiting,
        finishing,
        test_init,
        test_start,
        test_mode,
        advance_test,
        advance_test_wait,
        restart
    } ctrl_state_t;

    localparam cmd_t CMD_READ_REGION = 32'd1;
    localparam cmd_t CMD_START       = 32'd2;
    localparam cmd_t CMD_TEST_MODE   = 32'd3;
    localparam cmd_t CMD_RESTART     = 32'd4;

    localparam round_t LAST_ROUND = round_t'(ROUNDS - 1);

    // Linear approximation masks
    localparam block_t MASK_IN  = 64'h2104008000000000;
    localparam block_t MASK_OUT = 64'h0000000021040080;

    localparam subkey_t [0:ROUNDS-1] ROUND_KEYS = {
        48'h1b02effc7072, 48'h79aed9dbc9e5, 48'h55fc8a42cf99, 48'h72add6db351d,
        48'h7cec07eb53a8, 48'h63a53e507b2f, 48'hec84b7f618bc, 48'hf78a3ac13bfb
    };

    // S1 to S8, entry = row * 16 + column
    localparam logic [0:7][0:63][3:0] SBOX_TABLES = {
        256'he4d12fb83a6c5907_0f74e2d1a6cb9538_41e8d62bfc973a50_fc8249175b3ea06d,
        256'hf18e6b34972dc05a_3d47f28ec01a69b5_0e7ba4d158c6932f_d8a13f42b67c05e9,
        256'ha09e63f51dc7b428_d70934a6285ecbf1_d6498f30b12c5ae7_1ad069874fe3b52c,
        256'h7de3069a1285bc4f_d8b56f03472c1ae9_a690cb7df13e5284_3f06a1d8945bc72e,
        256'h2c417ab6853fd0e9_eb2c47d150fa3986_421bad78f9c5630e_b8c71e2d6f09a453,
        256'hc1af92680d34e75b_af427c9561de0b38_9ef528c3704a1db6_432c95fabe17608d,
        256'h4b2ef08d3c975a61_d0b7491ae35c2f86_14bdc37eaf680592_6bd814a7950fe23c,
        256'hd2846fb1a93e50c7_1fd8a374c56b0e92_7b419ce206adf358_21e74a8dfc90356b
    };

    // DES bit numbering, 1 is the MSB
    localparam logic [5:0] E_TABLE [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam logic [5:0] P_TABLE [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    function automatic half_t des_f(input half_t r, input subkey_t k);
        logic [47:0] x;
        logic [5:0] six;
        logic [4:0] pos;
        half_t s_out;
        half_t f;
        for (int i = 0; i < 48; i++) begin
            pos = 5'(6'd32 - E_TABLE[i]);
            x[47 - i] = r[pos];
        end
        x = x ^ k;
        for (int b = 0; b < 8; b++) begin
            six = x[47 - 6 * b -: 6];
            s_out[31 - 4 * b -: 4] = SBOX_TABLES[b][{six[5], six[0], six[4:1]}];   // Outer bits pick row
        end
        for (int i = 0; i < 32; i++) begin
            pos = 5'(6'd32 - P_TABLE[i]);
            f[31 - i] = s_out[pos];
        end
        return f;
    endfunction

endpackage

//--- verilog/linear_match.sv
`timescale 1ns/1ps

module linear_match
    import des_search_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clear,
    input  logic   block_valid,
    input  block_t plaintext,
    input  block_t cipher_out,
    output count_t match_count
);

    logic relation;

    // Zero when input and output parities agree
    assign relation = (^(plaintext & MASK_IN)) ^ (^(cipher_out & MASK_OUT));

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            match_count <= '0;
        end else if (block_valid && !relation) begin
            match_count <= match_count + 1'b1;
        end
    end

endmodule

//--- verilog/message_counter.sv
`timescale 1ns/1ps

module message_counter
    import des_search_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start_search,
    input  logic   restart_search,
    input  logic   test_enabled,
    input  logic   test_advance,
    input  logic   next_msg,
    output index_t index,
    output logic   exhausted
);

    // exhausted low means the current index is still waiting to be issued
    always_ff @(posedge clk) begin
        if (!rst_n || restart_search) begin
            index <= '0;
            exhausted <= 1'b1;
        end else if (start_search) begin
            index <= '0;
            exhausted <= 1'b0;
        end else if (test_enabled) begin
            if (test_advance) begin
                index <= index + 1'b1;
                exhausted <= 1'b0;
            end else if (next_msg && !exhausted) begin
                exhausted <= 1'b1;   // Single step, hold until advance
            end
        end else if (next_msg && !exhausted) begin
            if (&index) begin
                exhausted <= 1'b1;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

endmodule
